//--- dv/mainControl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mainControlSva (
    input logic                clk,
    input logic                rst,
    input controlPkg::phaseT   phase,
    input controlPkg::readRegT readReg,
    input controlPkg::stackOpT stackOp,
    input controlPkg::branchT  branch,
    input logic                muxA1,
    input logic                muxA2,
    input controlPkg::aluOpT   aluOp,
    input logic                muxWb,
    input controlPkg::memOpT   memOp,
    input logic                muxMemWrite,
    input logic                wReg,
    input logic                updatePC
);
    import controlPkg::*;

    logic outputsClear;

    function automatic phaseT followingPhase(phaseT p);
        case (p)
            phFetch:     return phWait;
            phWait:      return phRead;
            phRead:      return phOperand;
            phOperand:   return phExecute;
            phExecute:   return phMemory;
            phMemory:    return phWriteback;
            phWriteback: return phDone;
            default:     return phFetch;
        endcase
    endfunction

    assign outputsClear = readReg == rdNone && stackOp == spHold && branch == brNone
        && !muxA1 && !muxA2 && aluOp == aluAdd && !muxWb && memOp == memIdle
        && !muxMemWrite && !wReg;

    phaseOrder: assert property (@(posedge clk) !rst |=> phase == followingPhase($past(phase)))
        else $error("Phase sequence broken");

    clearAfterDone: assert property (@(posedge clk) (!rst && phase == phDone) |=> outputsClear)
        else $error("Control outputs not cleared after phDone");

    // Pulse is two cycles wide
    pulseWidth: assert property (@(posedge clk) (updatePC && $past(updatePC)) |-> !$past(updatePC, 2))
        else $error("updatePC high for three cycles");

endmodule

bind mainControl mainControlSva u_sva (.*);

`default_nettype wire

//--- dv/tbMainControl.sv
`timescale 1ns/1ps
`default_nettype none

module tbMainControl;
    import controlPkg::*;

    localparam int clkPeriod = 8;
    localparam int timeoutNs = 40 * 8 * clkPeriod + 10 * clkPeriod;

    typedef struct packed {
        readRegT readReg;
        stackOpT stackOp;
        branchT  branch;
        logic    muxA1;
        logic    muxA2;
        aluOpT   aluOp;
        logic    muxWb;
        memOpT   memOp;
        logic    muxMemWrite;
        logic    wReg;
    } ctrlT;

    logic    clk;
    logic    rst;
    opcodeT  opcode;
    funcT    func;
    readRegT readReg;
    stackOpT stackOp;
    branchT  branch;
    logic    muxA1;
    logic    muxA2;
    aluOpT   aluOp;
    logic    muxWb;
    memOpT   memOp;
    logic    muxMemWrite;
    logic    wReg;
    logic    updatePC;

    logic [15:0] lfsr;
    int          errorCount;
    int          checkCount;

    mainControl u_dut (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .func        (func),
        .readReg     (readReg),
        .stackOp     (stackOp),
        .branch      (branch),
        .muxA1       (muxA1),
        .muxA2       (muxA2),
        .aluOp       (aluOp),
        .muxWb       (muxWb),
        .memOp       (memOp),
        .muxMemWrite (muxMemWrite),
        .wReg        (wReg),
        .updatePC    (updatePC)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit
    function automatic logic [5:0] randomField();
        logic [5:0] bits;
        bits = '0;
        for (int i = 0; i < 6; i++) begin
            lfsr = lfsrStep(lfsr);
            bits = {bits[4:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Expected control word of the tested instructions
    function automatic ctrlT expectedFor(opcodeT op, funcT fn);
        ctrlT c;
        c = '0;
        case (op)
            opAluReg: begin
                if (fn == 6'd1) begin
                    c.readReg = rdTwo;
                    c.aluOp   = aluSub;
                    c.wReg    = 1'b1;
                end
            end
            opLogicReg: begin
                if (fn == 6'd2) begin
                    c.readReg = rdTwo;
                    c.aluOp   = aluLogicC;
                    c.wReg    = 1'b1;
                end
            end
            opShiftReg: begin
                if (fn == 6'd1) begin
                    c.readReg = rdTwo;
                    c.aluOp   = aluShiftC;
                    c.wReg    = 1'b1;
                end
            end
            opLoad: begin
                c.readReg = rdOne;
                c.muxA2   = 1'b1;
                c.muxWb   = 1'b1;
                c.memOp   = memRead;
                c.wReg    = 1'b1;
            end
            opStore: begin
                c.readReg = rdTwo;
                c.muxA2   = 1'b1;
                c.memOp   = memWrite;
            end
            opPush: begin
                c.readReg = rdStack;
                c.stackOp = spDec;
                c.muxA1   = 1'b1;
                c.memOp   = memWrite;
            end
            opPop: begin
                c.stackOp = spInc;
                c.muxA1   = 1'b1;
                c.muxA2   = 1'b1;
                c.muxWb   = 1'b1;
                c.memOp   = memRead;
                c.wReg    = 1'b1;
            end
            opJump: c.branch = (fn == 6'd0) ? brJump : brNone;
            opBranch: begin
                c.readReg = rdOne;
                c.branch  = brCond;
                c.aluOp   = aluCmp;
            end
            opCall: begin
                c.stackOp     = spDec;
                c.branch      = brCall;
                c.muxA1       = 1'b1;
                c.memOp       = memWrite;
                c.muxMemWrite = 1'b1;
            end
            opReturn: begin
                c.stackOp = spInc;
                c.branch  = brReturn;
                c.muxA1   = 1'b1;
                c.muxA2   = 1'b1;
                c.memOp   = memRead;
            end
            opJumpReg: c.branch = brReg;
            default: c = '0;
        endcase
        return c;
    endfunction

    task automatic compareReadReg(string name, readRegT got, readRegT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareStackOp(string name, stackOpT got, stackOpT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareBranch(string name, branchT got, branchT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareMemOp(string name, memOpT got, memOpT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareAluOp(string name, aluOpT got, aluOpT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Cycle k counts from the phRead cycle of the sequence
    task automatic checkPhaseOutputs(int k, ctrlT e);
        ctrlT want;
        want = '0;
        if (k >= 1 && k <= 5) begin
            want.readReg = e.readReg;
            want.stackOp = e.stackOp;
            want.branch  = e.branch;
            if (k >= 2) begin
                want.muxA1 = e.muxA1;
                want.muxA2 = e.muxA2;
            end
            if (k >= 3) begin
                want.aluOp = e.aluOp;
            end
            if (k >= 4) begin
                want.muxWb       = e.muxWb;
                want.memOp       = e.memOp;
                want.muxMemWrite = e.muxMemWrite;
            end
            if (k >= 5) begin
                want.wReg = e.wReg;
            end
        end
        compareReadReg("readReg", readReg, want.readReg);
        compareStackOp("stackOp", stackOp, want.stackOp);
        compareBranch("branch", branch, want.branch);
        compareBit("muxA1", muxA1, want.muxA1);
        compareBit("muxA2", muxA2, want.muxA2);
        compareAluOp("aluOp", aluOp, want.aluOp);
        compareBit("muxWb", muxWb, want.muxWb);
        compareMemOp("memOp", memOp, want.memOp);
        compareBit("muxMemWrite", muxMemWrite, want.muxMemWrite);
        compareBit("wReg", wReg, want.wReg);
        compareBit("updatePC", updatePC, k >= 6);
    endtask

    // Starts and ends in the middle of a phWait cycle
    task automatic runSequence(opcodeT op, funcT fn, logic scramble);
        ctrlT e;
        e = expectedFor(op, fn);
        opcode = op;
        func   = fn;
        @(negedge clk);
        checkPhaseOutputs(0, e);
        for (int k = 1; k < 8; k++) begin
            @(negedge clk);
            checkPhaseOutputs(k, e);
            if (scramble && k == 1) begin
                opcode = opcodeT'(randomField());
                func   = randomField();
            end
        end
    endtask

    task automatic resetTest();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkPhaseOutputs(0, '0);
        end
        rst = 1'b0;
        @(negedge clk);
        checkPhaseOutputs(0, '0);
    endtask

    task automatic aluRegTest();
        runSequence(opAluReg, 6'd1, 1'b0);
        runSequence(opLogicReg, 6'd2, 1'b0);
        runSequence(opShiftReg, 6'd1, 1'b0);
    endtask

    task automatic memStackTest();
        runSequence(opLoad, 6'd0, 1'b0);
        runSequence(opStore, 6'd0, 1'b0);
        runSequence(opPush, 6'd0, 1'b0);
        runSequence(opPop, 6'd0, 1'b0);
    endtask

    task automatic branchTest();
        runSequence(opJump, 6'd0, 1'b0);
        runSequence(opBranch, randomField(), 1'b0);
        runSequence(opCall, 6'd0, 1'b0);
        runSequence(opReturn, 6'd0, 1'b0);
        runSequence(opJumpReg, 6'd0, 1'b0);
    endtask

    // Unlisted pair and nop both decode to zero
    task automatic clearPulseTest();
        runSequence(opAluReg, 6'd7, 1'b0);
        runSequence(opNop, 6'd0, 1'b0);
    endtask

    task automatic captureHoldTest();
        runSequence(opPop, 6'd0, 1'b1);
        runSequence(opCall, 6'd0, 1'b1);
    endtask

    initial begin
        #(timeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", timeoutNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        opcode     = opNop;
        func       = '0;
        lfsr       = 16'd11;
        errorCount = 0;
        checkCount = 0;
        resetTest();
        aluRegTest();
        memStackTest();
        branchTest();
        clearPulseTest();
        captureHoldTest();
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/controlPkg.sv
rtl/phaseSequencer.sv
rtl/instrDecoder.sv
rtl/controlRegs.sv
rtl/mainControl.sv
dv/mainControl_sva.sv
dv/tbMainControl.sv

//--- rtl/controlPkg.sv
`default_nettype none

package controlPkg;

    localparam int opcodeWidth = 6;
    localparam int funcWidth   = 6;
    localparam int aluOpWidth  = 4;
    localparam int phaseWidth  = 4;

    typedef enum logic [opcodeWidth-1:0] {
        opAluReg    = 6'd0,
        opLogicReg  = 6'd1,
        opUnaryReg  = 6'd2,
        opShiftReg  = 6'd3,
        opAddImm    = 6'd4,
        opSubImm    = 6'd5,
        opLogicImmA = 6'd6,
        opLogicImmB = 6'd7,
        opLogicImmC = 6'd8,
        opLoadImm   = 6'd9,
        opShiftImmA = 6'd10,
        opShiftImmB = 6'd11,
        opShiftImmC = 6'd12,
        opLoad      = 6'd13,
        opStore     = 6'd14,
        opLoadSp    = 6'd15,
        opStorePc   = 6'd16,
        opMove      = 6'd17,
        opPush      = 6'd18,
        opPop       = 6'd19,
        opJump      = 6'd20,
        opBranch    = 6'd21,
        opCall      = 6'd22,
        opReturn    = 6'd23,
        opJumpReg   = 6'd24,
        opNop       = 6'd25
    } opcodeT;

    typedef logic [funcWidth-1:0] funcT;

    typedef enum logic [aluOpWidth-1:0] {
        aluAdd    = 4'd0,
        aluSub    = 4'd1,
        aluCmp    = 4'd2,
        aluShiftA = 4'd3,
        aluShiftB = 4'd4,
        aluLogicA = 4'd5,
        aluUnary  = 4'd6,
        aluLogicB = 4'd7,
        aluLogicC = 4'd8,
        aluShiftC = 4'd9
    } aluOpT;

    typedef enum logic [1:0] {rdNone = 2'd0, rdStack = 2'd1, rdOne = 2'd2, rdTwo = 2'd3} readRegT;

    typedef enum logic [1:0] {spHold = 2'd0, spInc = 2'd1, spDec = 2'd2, spLoad = 2'd3} stackOpT;

    typedef enum logic [1:0] {memIdle = 2'd0, memWrite = 2'd1, memRead = 2'd2} memOpT;

    typedef enum logic [2:0] {
        brNone   = 3'd0,
        brJump   = 3'd1,
        brCond   = 3'd2,
        brCall   = 3'd3,
        brReturn = 3'd4,
        brReg    = 3'd5
    } branchT;

    // Eight-cycle instruction sequence
    typedef enum logic [phaseWidth-1:0] {
        phFetch     = 4'd0,
        phWait      = 4'd1,
        phRead      = 4'd2,
        phOperand   = 4'd3,
        phExecute   = 4'd4,
        phMemory    = 4'd5,
        phWriteback = 4'd6,
        phDone      = 4'd15
    } phaseT;

endpackage

`default_nettype wire

//--- rtl/controlRegs.sv
`timescale 1ns/1ps
`default_nettype none

module controlRegs (
    input  logic                clk,
    input  logic                rst,
    input  controlPkg::phaseT   phase,
    input  controlPkg::opcodeT  opcode,
    input  controlPkg::funcT    func,
    input  controlPkg::readRegT decReadReg,
    input  controlPkg::stackOpT decStackOp,
    input  controlPkg::branchT  decBranch,
    input  logic                decMuxA1,
    input  logic                decMuxA2,
    input  controlPkg::aluOpT   decAluOp,
    input  logic                decMuxWb,
    input  controlPkg::memOpT   decMemOp,
    input  logic                decMuxMemWrite,
    input  logic                decWReg,
    output controlPkg::opcodeT  curOpcode,
    output controlPkg::funcT    curFunc,
    output controlPkg::readRegT readReg,
    output controlPkg::stackOpT stackOp,
    output controlPkg::branchT  branch,
    output logic                muxA1,
    output logic                muxA2,
    output controlPkg::aluOpT   aluOp,
    output logic                muxWb,
    output controlPkg::memOpT   memOp,
    output logic                muxMemWrite,
    output logic                wReg
);
    import controlPkg::*;

    opcodeT capOpcode;
    funcT   capFunc;

    always_ff @(posedge clk) begin
        if (phase == phRead) begin
            capOpcode <= opcode;
            capFunc   <= func;
        end
    end

    // Decoder sees the live pair in phRead, the captured one after
    always_comb begin
        if (phase == phRead) begin
            curOpcode = opcode;
            curFunc   = func;
        end else begin
            curOpcode = capOpcode;
            curFunc   = capFunc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || phase == phDone) begin
            readReg     <= rdNone;
            stackOp     <= spHold;
            branch      <= brNone;
            muxA1       <= 1'b0;
            muxA2       <= 1'b0;
            aluOp       <= aluAdd;
            muxWb       <= 1'b0;
            memOp       <= memIdle;
            muxMemWrite <= 1'b0;
            wReg        <= 1'b0;
        end else begin
            case (phase)
                phRead: begin
                    readReg <= decReadReg;
                    stackOp <= decStackOp;
                    branch  <= decBranch;
                end
                phOperand: begin
                    muxA1 <= decMuxA1;
                    muxA2 <= decMuxA2;
                end
                phExecute:   aluOp <= decAluOp;
                phMemory: begin
                    muxWb       <= decMuxWb;
                    memOp       <= decMemOp;
                    muxMemWrite <= decMuxMemWrite;
                end
                phWriteback: wReg <= decWReg;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  controlPkg::opcodeT  opcode,
    input  controlPkg::funcT    func,
    output controlPkg::readRegT readReg,
    output controlPkg::stackOpT stackOp,
    output controlPkg::branchT  branch,
    output logic                muxA1,
    output logic                muxA2,
    output controlPkg::aluOpT   aluOp,
    output logic                muxWb,
    output controlPkg::memOpT   memOp,
    output logic                muxMemWrite,
    output logic                wReg
);
    import controlPkg::*;

    aluOpT aluSel;
    logic  regHit;

    // ALU operation of the register and immediate ALU forms
    always_comb begin
        regHit = 1'b1;
        aluSel = aluAdd;
        case (opcode)
            opAluReg: begin
                case (func)
                    6'd0: aluSel = aluAdd;
                    6'd1: aluSel = aluSub;
                    default: regHit = 1'b0;
                endcase
            end
            opLogicReg: begin
                case (func)
                    6'd0: aluSel = aluLogicA;
                    6'd1: aluSel = aluLogicB;
                    6'd2: aluSel = aluLogicC;
                    default: regHit = 1'b0;
                endcase
            end
            opUnaryReg: begin
                if (func == 6'd0) begin
                    aluSel = aluUnary;
                end else begin
                    regHit = 1'b0;
                end
            end
            opShiftReg: begin
                case (func)
                    6'd0: aluSel = aluShiftA;
                    6'd1: aluSel = aluShiftC;
                    6'd2: aluSel = aluShiftB;
                    default: regHit = 1'b0;
                endcase
            end
            opSubImm:    aluSel = aluSub;
            opLogicImmA: aluSel = aluLogicA;
            opLogicImmB: aluSel = aluLogicB;
            opLogicImmC: aluSel = aluLogicC;
            opLoadImm:   aluSel = aluUnary;
            opShiftImmA: aluSel = aluShiftA;
            opShiftImmB: aluSel = aluShiftC;
            opShiftImmC: aluSel = aluShiftB;
            default:     regHit = 1'b0;
        endcase
    end

    always_comb begin
        readReg     = rdNone;
        stackOp     = spHold;
        branch      = brNone;
        muxA1       = 1'b0;
        muxA2       = 1'b0;
        aluOp       = aluAdd;
        muxWb       = 1'b0;
        memOp       = memIdle;
        muxMemWrite = 1'b0;
        wReg        = 1'b0;
        case (opcode)
            opAluReg, opLogicReg, opUnaryReg, opShiftReg: begin
                if (regHit) begin
                    // Unary form has a single source register
                    if (opcode == opUnaryReg) begin
                        readReg = rdOne;
                    end else begin
                        readReg = rdTwo;
                    end
                    aluOp = aluSel;
                    wReg  = 1'b1;
                end
            end
            opAddImm, opSubImm, opLogicImmA, opLogicImmB, opLogicImmC,
            opLoadImm, opShiftImmA, opShiftImmB, opShiftImmC: begin
                // Load-immediate needs no source register
                if (opcode != opLoadImm) begin
                    readReg = rdOne;
                end
                muxA2 = 1'b1;
                aluOp = aluSel;
                wReg  = 1'b1;
            end
            opLoad: begin
                readReg = rdOne;
                muxA2   = 1'b1;
                muxWb   = 1'b1;
                memOp   = memRead;
                wReg    = 1'b1;
            end
            opStore: begin
                readReg = rdTwo;
                muxA2   = 1'b1;
                memOp   = memWrite;
            end
            opLoadSp: begin
                readReg = rdOne;
                stackOp = spLoad;
                muxA2   = 1'b1;
                memOp   = memRead;
            end
            opStorePc: begin
                readReg     = rdOne;
                muxA2       = 1'b1;
                memOp       = memWrite;
                muxMemWrite = 1'b1;
            end
            opMove: begin
                readReg = rdTwo;
                wReg    = 1'b1;
            end
            opPush: begin
                readReg = rdStack;
                stackOp = spDec;
                muxA1   = 1'b1;
                memOp   = memWrite;
            end
            opPop: begin
                stackOp = spInc;
                muxA1   = 1'b1;
                muxA2   = 1'b1;
                muxWb   = 1'b1;
                memOp   = memRead;
                wReg    = 1'b1;
            end
            opJump: begin
                if (func == 6'd0) begin
                    branch = brJump;
                end
            end
            // Condition code sits in func, so every func is a branch
            opBranch: begin
                readReg = rdOne;
                branch  = brCond;
                aluOp   = aluCmp;
            end
            opCall: begin
                if (func == 6'd0) begin
                    stackOp     = spDec;
                    branch      = brCall;
                    muxA1       = 1'b1;
                    memOp       = memWrite;
                    muxMemWrite = 1'b1;
                end
            end
            opReturn: begin
                if (func == 6'd0) begin
                    stackOp = spInc;
                    branch  = brReturn;
                    muxA1   = 1'b1;
                    muxA2   = 1'b1;
                    memOp   = memRead;
                end
            end
            opJumpReg: begin
                if (func == 6'd0) begin
                    branch = brReg;
                end
            end
            // Nop and unknown pairs leave every control at zero
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mainControl.sv
`timescale 1ns/1ps
`default_nettype none

module mainControl (
    input  logic                clk,
    input  logic                rst,
    input  controlPkg::opcodeT  opcode,
    input  controlPkg::funcT    func,
    output controlPkg::readRegT readReg,
    output controlPkg::stackOpT stackOp,
    output controlPkg::branchT  branch,
    output logic                muxA1,
    output logic                muxA2,
    output controlPkg::aluOpT   aluOp,
    output logic                muxWb,
    output controlPkg::memOpT   memOp,
    output logic                muxMemWrite,
    output logic                wReg,
    output logic                updatePC
);
    import controlPkg::*;

    phaseT   phase;
    opcodeT  curOpcode;
    funcT    curFunc;
    readRegT decReadReg;
    stackOpT decStackOp;
    branchT  decBranch;
    logic    decMuxA1;
    logic    decMuxA2;
    aluOpT   decAluOp;
    logic    decMuxWb;
    memOpT   decMemOp;
    logic    decMuxMemWrite;
    logic    decWReg;

    phaseSequencer u_sequencer (
        .clk      (clk),
        .rst      (rst),
        .phase    (phase),
        .updatePC (updatePC)
    );

    instrDecoder u_decoder (
        .opcode      (curOpcode),
        .func        (curFunc),
        .readReg     (decReadReg),
        .stackOp     (decStackOp),
        .branch      (decBranch),
        .muxA1       (decMuxA1),
        .muxA2       (decMuxA2),
        .aluOp       (decAluOp),
        .muxWb       (decMuxWb),
        .memOp       (decMemOp),
        .muxMemWrite (decMuxMemWrite),
        .wReg        (decWReg)
    );

    controlRegs u_regs (
        .clk            (clk),
        .rst            (rst),
        .phase          (phase),
        .opcode         (opcode),
        .func           (func),
        .decReadReg     (decReadReg),
        .decStackOp     (decStackOp),
        .decBranch      (decBranch),
        .decMuxA1       (decMuxA1),
        .decMuxA2       (decMuxA2),
        .decAluOp       (decAluOp),
        .decMuxWb       (decMuxWb),
        .decMemOp       (decMemOp),
        .decMuxMemWrite (decMuxMemWrite),
        .decWReg        (decWReg),
        .curOpcode      (curOpcode),
        .curFunc        (curFunc),
        .readReg        (readReg),
        .stackOp        (stackOp),
        .branch         (branch),
        .muxA1          (muxA1),
        .muxA2          (muxA2),
        .aluOp          (aluOp),
        .muxWb          (muxWb),
        .memOp          (memOp),
        .muxMemWrite    (muxMemWrite),
        .wReg           (wReg)
    );

endmodule

`default_nettype wire

//--- rtl/phaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
    input  logic              clk,
    input  logic              rst,
    output controlPkg::phaseT phase,
    output logic              updatePC
);
    import controlPkg::*;

    phaseT nextPhase;

    always_comb begin
        case (phase)
            phFetch:     nextPhase = phWait;
            phWait:      nextPhase = phRead;
            phRead:      nextPhase = phOperand;
            phOperand:   nextPhase = phExecute;
            phExecute:   nextPhase = phMemory;
            phMemory:    nextPhase = phWriteback;
            phWriteback: nextPhase = phDone;
            // phDone, and any stray code, restarts the sequence
            default:     nextPhase = phFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= phFetch;
            updatePC <= 1'b0;
        end else begin
            phase <= nextPhase;
            // Pulse covers fetch and wait of the next instruction
            if (phase == phDone) begin
                updatePC <= 1'b1;
            end else if (phase == phWait) begin
                updatePC <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tbMainControl -Mdir obj_dir \
    -o simMainControl -f project.f \
    && ./obj_dir/simMainControl > sim.log 2>&1
cat sim.log 2>/dev/null
test -f sim.log && ! grep -qF '*** TEST FAILED ***' sim.log \
    && grep -qF '*** TEST PASSED ***' sim.log \
    || { echo "Simulation failed"; exit 1; }
